// ==== csa_reduce.sv ====
`default_nettype none

module csa_reduce (
  digit_pp_if.dst i_pp,
  lane_cs_if.src  o_cs
);
  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  // per lane sum/carry after the last row
  lane_acc_t lane_s [NUM_LANES];
  lane_acc_t lane_c [NUM_LANES];

  // one 3:2 row per digit product and sixteen rows per lane
  // products of other lanes enter as zero
  always_comb
  begin
    lane_acc_t s;
    lane_acc_t c;
    lane_acc_t a;
    lane_acc_t row_s;
    lane_acc_t row_c;
    int unsigned shift;
    for (int k = 0; k < NUM_LANES; k++)
    begin
      s = '0;
      c = '0;
      for (int i = 0; i < NUM_DIGITS; i++)
      begin
        for (int j = 0; j < NUM_DIGITS; j++)
        begin
          // weight of the product is 4^(data pos + mag pos)
          shift = DIGIT_W * (digit_pos(i_pp.mode, i) + j);
          if (lane_of_digit(i_pp.mode, i) == k)
          begin
            a = lane_acc_t'(i_pp.pp[i][j]) << shift;
          end
          else
          begin
            a = '0;
          end
          // full adder per bit with carries moved up one place
          row_s = s ^ c ^ a;
          row_c = ((s & c) | (s & a) | (c & a)) << 1;
          s = row_s;
          c = row_c;
        end
      end
      lane_s[k] = s;
      lane_c[k] = c;
    end
  end

  // true sum stays below 2^15 so dropped top carries are harmless
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      o_cs.sum[k]   = lane_s[k];
      o_cs.carry[k] = lane_c[k];
    end
  end

  // control travels alongside
  assign o_cs.sign  = i_pp.sign;
  assign o_cs.mode  = i_pp.mode;
  assign o_cs.valid = i_pp.valid;

  // lanes above the mode's count hold no products and no weight sign from decode
  for (genvar k = 0; k < NUM_LANES; k++)
  begin : g_idle_chk
    a_idle_lane_zero : assert property (
      @(posedge i_pp.clk)
      (i_pp.valid && (k >= lane_count(i_pp.mode)))
        |-> (!i_pp.sign[k] && (lane_s[k] == '0) && (lane_c[k] == '0))
    ) else $error("idle lane %0d has a nonzero carry-save pair or a set sign", k);
  end

endmodule

`default_nettype wire

// ==== digit_pp_if.sv ====
`default_nettype none

// decode register to carry-save stage
interface digit_pp_if (
  input wire clk
);
  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  // pp[i][j] = data digit i * magnitude digit j of lane(i)
  dprod_t               pp [NUM_DIGITS][NUM_DIGITS];
  // weight sign per lane, low for idle lanes
  logic [NUM_LANES-1:0] sign;
  prec_mode_t           mode;
  logic                 valid;

  modport src (
    input  clk,
    output pp, sign, mode, valid
  );

  // clk only for checks in the combinational reader
  modport dst (
    input clk, pp, sign, mode, valid
  );

endinterface

`default_nettype wire

// ==== lane_cs_if.sv ====
`default_nettype none

// carry-save pairs per lane into the final adder
interface lane_cs_if;
  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  // sum + carry is the unsigned lane magnitude
  lane_acc_t            sum   [NUM_LANES];
  lane_acc_t            carry [NUM_LANES];
  logic [NUM_LANES-1:0] sign;
  prec_mode_t           mode;
  logic                 valid;

  modport src (
    output sum, carry, sign, mode, valid
  );

  modport dst (
    input sum, carry, sign, mode, valid
  );

endinterface

`default_nettype wire

// ==== lane_result.sv ====
`default_nettype none

module lane_result (
  input  wire                 clk,
  input  wire                 i_rst_n,
  lane_cs_if.dst              i_cs,
  output logic                o_valid,
  output mul_operand_pkg::product_t o_mul1,
  output mul_operand_pkg::product_t o_mul2,
  output mul_operand_pkg::product_t o_mul3,
  output mul_operand_pkg::product_t o_mul4
);
  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  // two-level lookahead, groups of four bits
  function automatic lane_acc_t cla_add(lane_acc_t a, lane_acc_t b);
    lane_acc_t           g;
    lane_acc_t           p;
    lane_acc_t           c;
    logic [CLA_NGRP-1:0] grp_g;
    logic [CLA_NGRP-1:0] grp_p;
    logic [CLA_NGRP-1:0] grp_c;
    g = a & b;
    p = a ^ b;
    for (int n = 0; n < CLA_NGRP; n++)
    begin
      grp_g[n] = 1'b0;
      grp_p[n] = 1'b1;
      for (int i = n * CLA_GRP; i < (n + 1) * CLA_GRP; i++)
      begin
        if (i < ACC_W)
        begin
          grp_g[n] = g[i] | (p[i] & grp_g[n]);
          grp_p[n] = grp_p[n] & p[i];
        end
      end
    end
    // carry into each group, no carry-in at bit 0
    grp_c[0] = 1'b0;
    for (int n = 0; n < CLA_NGRP - 1; n++)
    begin
      grp_c[n+1] = grp_g[n] | (grp_p[n] & grp_c[n]);
    end
    // bit carries inside a group start from its group carry
    for (int n = 0; n < CLA_NGRP; n++)
    begin
      c[n * CLA_GRP] = grp_c[n];
      for (int i = n * CLA_GRP + 1; i < (n + 1) * CLA_GRP; i++)
      begin
        if (i < ACC_W)
        begin
          c[i] = g[i-1] | (p[i-1] & c[i-1]);
        end
      end
    end
    return p ^ c;
  endfunction

  // unsigned magnitude per lane
  lane_acc_t lane_sum  [NUM_LANES];
  product_t  lane_prod [NUM_LANES];
  product_t  mul_q     [NUM_LANES];
  logic      valid_q;
  // largest legal magnitude for the mode
  lane_acc_t max_mag;

  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      lane_sum[k] = cla_add(i_cs.sum[k], i_cs.carry[k]);
      // two's complement negate for negative weights
      lane_prod[k] = i_cs.sign[k] ? product_t'(-lane_sum[k]) : product_t'(lane_sum[k]);
    end
  end

  always_comb
  begin
    case (i_cs.mode)
      MODE_P8: max_mag = lane_acc_t'((2**DATA_W - 1) * 2**(WEIGHT_W - 1));
      MODE_P4: max_mag = lane_acc_t'((2**(2 * DIGIT_W) - 1) * 2**(2 * DIGIT_W - 1));
      default: max_mag = lane_acc_t'((2**DIGIT_W - 1) * 2**(DIGIT_W - 1));
    endcase
  end

  // products read zero whenever no result is out
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      valid_q <= 1'b0;
      mul_q   <= '{default: '0};
    end
    else
    begin
      valid_q <= i_cs.valid;
      for (int k = 0; k < NUM_LANES; k++)
      begin
        mul_q[k] <= i_cs.valid ? lane_prod[k] : '0;
      end
    end
  end

  assign o_valid = valid_q;
  assign o_mul1  = mul_q[0];
  assign o_mul2  = mul_q[1];
  assign o_mul3  = mul_q[2];
  assign o_mul4  = mul_q[3];

  // whole datapath from decode to adder stays inside the mode's range
  for (genvar k = 0; k < NUM_LANES; k++)
  begin : g_range_chk
    a_lane_in_range : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_cs.valid |-> (lane_sum[k] <= max_mag)
    ) else $error("lane %0d magnitude %0d out of range", k, lane_sum[k]);
  end

endmodule

`default_nettype wire

// ==== mul_operand_pkg.sv ====
`default_nettype none

package mul_operand_pkg;

  // activation and weight word widths
  localparam int unsigned DATA_W   = 8;
  localparam int unsigned WEIGHT_W = 8;

  // radix-4 digits, four per operand
  localparam int unsigned DIGIT_W    = 2;
  localparam int unsigned NUM_DIGITS = DATA_W / DIGIT_W;
  localparam int unsigned DPROD_W    = 2 * DIGIT_W;

  // at most one lane per data digit
  localparam int unsigned NUM_LANES = 4;

  // one bit of headroom over the widest 8x8 magnitude
  localparam int unsigned ACC_W  = 17;
  localparam int unsigned PROD_W = 16;

  // final adder lookahead groups
  localparam int unsigned CLA_GRP  = 4;
  localparam int unsigned CLA_NGRP = (ACC_W + CLA_GRP - 1) / CLA_GRP;

  // unsigned activation
  typedef logic        [DATA_W-1:0]   data_t;
  // signed weight word, low field used in P4 and P2
  typedef logic signed [WEIGHT_W-1:0] weight_t;
  // magnitude of a weight, 128 must fit
  typedef logic        [WEIGHT_W-1:0] mag_t;
  typedef logic        [DIGIT_W-1:0]  digit_t;
  typedef logic        [DPROD_W-1:0]  dprod_t;
  // one carry-save vector of a lane
  typedef logic        [ACC_W-1:0]    lane_acc_t;
  typedef logic signed [PROD_W-1:0]   product_t;

endpackage

`default_nettype wire

// ==== multi_precision_mul.f ====
+incdir+.
mul_operand_pkg.sv
prec_mode_pkg.sv
digit_pp_if.sv
lane_cs_if.sv
operand_decode.sv
csa_reduce.sv
lane_result.sv
multi_precision_mul.sv
tb_multi_precision_mul.sv

// ==== multi_precision_mul.sv ====
`default_nettype none

module multi_precision_mul (
  input  wire                            clk,
  input  wire                            i_rst_n,
  input  wire                            i_valid,
  input  wire prec_mode_pkg::prec_mode_t i_mode,
  input  wire mul_operand_pkg::data_t    i_data,
  input  wire mul_operand_pkg::weight_t  i_w1,
  input  wire mul_operand_pkg::weight_t  i_w2,
  input  wire mul_operand_pkg::weight_t  i_w3,
  input  wire mul_operand_pkg::weight_t  i_w4,
  output wire                            o_valid,
  output wire mul_operand_pkg::product_t o_mul1,
  output wire mul_operand_pkg::product_t o_mul2,
  output wire mul_operand_pkg::product_t o_mul3,
  output wire mul_operand_pkg::product_t o_mul4
);

  // registered digit products, stage 1
  digit_pp_if pp_bus (
    .clk (clk)
  );

  // combinational carry-save pairs
  lane_cs_if cs_bus ();

  operand_decode i_operand_decode (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_mode  (i_mode),
    .i_data  (i_data),
    .i_w1    (i_w1),
    .i_w2    (i_w2),
    .i_w3    (i_w3),
    .i_w4    (i_w4),
    .o_pp    (pp_bus)
  );

  csa_reduce i_csa_reduce (
    .i_pp (pp_bus),
    .o_cs (cs_bus)
  );

  // stage 2, outputs two cycles after the input edge
  lane_result i_lane_result (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_cs    (cs_bus),
    .o_valid (o_valid),
    .o_mul1  (o_mul1),
    .o_mul2  (o_mul2),
    .o_mul3  (o_mul3),
    .o_mul4  (o_mul4)
  );

endmodule

`default_nettype wire

// ==== operand_decode.sv ====
`default_nettype none

module operand_decode (
  input  wire                           clk,
  input  wire                           i_rst_n,
  input  wire                           i_valid,
  input  wire prec_mode_pkg::prec_mode_t i_mode,
  input  wire mul_operand_pkg::data_t   i_data,
  input  wire mul_operand_pkg::weight_t i_w1,
  input  wire mul_operand_pkg::weight_t i_w2,
  input  wire mul_operand_pkg::weight_t i_w3,
  input  wire mul_operand_pkg::weight_t i_w4,
  digit_pp_if.src                       o_pp
);
  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  // raw weight word per lane
  weight_t              w     [NUM_LANES];
  // weight field sign-extended from the mode width
  weight_t              w_ext [NUM_LANES];
  mag_t                 mag   [NUM_LANES];
  logic [NUM_LANES-1:0] w_neg;
  logic [NUM_LANES-1:0] w_sign;
  // 4x4 array of 2x2 digit products
  dprod_t               pp_d  [NUM_DIGITS][NUM_DIGITS];

  assign w[0] = i_w1;
  assign w[1] = i_w2;
  assign w[2] = i_w3;
  assign w[3] = i_w4;

  // sign/magnitude split per lane
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      case (i_mode)
        MODE_P8: w_ext[k] = w[k];
        // low nibble, sign at bit 3
        MODE_P4: w_ext[k] = weight_t'({{(WEIGHT_W - 2 * DIGIT_W){w[k][2 * DIGIT_W - 1]}},
                                       w[k][2 * DIGIT_W - 1:0]});
        // low crumb, also for reserved 00
        default: w_ext[k] = weight_t'({{(WEIGHT_W - DIGIT_W){w[k][DIGIT_W - 1]}},
                                       w[k][DIGIT_W - 1:0]});
      endcase
      w_neg[k] = w_ext[k][WEIGHT_W-1];
      // -128 gives 8'h80, still correct as unsigned
      mag[k] = w_neg[k] ? mag_t'(-w_ext[k]) : mag_t'(w_ext[k]);
      // idle lanes never negate
      w_sign[k] = w_neg[k] && (k < lane_count(i_mode));
    end
  end

  // digit i of the data meets the magnitude of its own lane
  always_comb
  begin
    digit_t d_dig;
    digit_t m_dig;
    int unsigned lane;
    for (int i = 0; i < NUM_DIGITS; i++)
    begin
      lane  = lane_of_digit(i_mode, i);
      d_dig = i_data[i * DIGIT_W +: DIGIT_W];
      for (int j = 0; j < NUM_DIGITS; j++)
      begin
        // upper digits are zero beyond the lane's field
        m_dig = mag[lane][j * DIGIT_W +: DIGIT_W];
        pp_d[i][j] = dprod_t'(d_dig) * dprod_t'(m_dig);
      end
    end
  end

  // valid is the only control bit
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_pp.valid <= 1'b0;
    end
    else
    begin
      o_pp.valid <= i_valid;
    end
  end

  // payload only moves with a live set
  always_ff @(posedge clk)
  begin
    if (i_valid)
    begin
      o_pp.pp   <= pp_d;
      o_pp.sign <= w_sign;
      o_pp.mode <= i_mode;
    end
  end

  // reserved mode would silently run as P2
  a_no_rsvd_mode : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_valid |-> (i_mode != MODE_RSVD)
  ) else $error("valid operand set with reserved mode 00");

endmodule

`default_nettype wire

// ==== prec_mode_pkg.sv ====
`default_nettype none

package prec_mode_pkg;

  typedef logic [1:0] prec_mode_t;

  // 00 is reserved, handled as P2
  localparam prec_mode_t MODE_RSVD = 2'b00;
  localparam prec_mode_t MODE_P2   = 2'b01;
  localparam prec_mode_t MODE_P4   = 2'b10;
  localparam prec_mode_t MODE_P8   = 2'b11;

  // live lanes per mode
  localparam int unsigned LANES_P2 = 4;
  localparam int unsigned LANES_P4 = 2;
  localparam int unsigned LANES_P8 = 1;

  function automatic int unsigned lane_count(prec_mode_t m);
    case (m)
      MODE_P8: return LANES_P8;
      MODE_P4: return LANES_P4;
      default: return LANES_P2;
    endcase
  endfunction

  // lane that owns data digit d
  function automatic int unsigned lane_of_digit(prec_mode_t m, int unsigned d);
    case (m)
      MODE_P8: return 0;
      MODE_P4: return d >> 1;
      default: return d;
    endcase
  endfunction

  // digit position of data digit d inside its lane
  function automatic int unsigned digit_pos(prec_mode_t m, int unsigned d);
    case (m)
      MODE_P8: return d;
      MODE_P4: return d & 1;
      default: return 0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== tb_mul_model.svh ====
`ifndef TB_MUL_MODEL_SVH
`define TB_MUL_MODEL_SVH

// expected lane products built straight from the routing rules

// two's complement value of the low bits of a weight
function automatic int weight_field(weight_t w, int unsigned bits);
  int unsigned raw;
  raw = w[WEIGHT_W-1:0];
  raw = raw & ((32'd1 << bits) - 1);
  if (raw >= (32'd1 << (bits - 1)))
  begin
    return int'(raw) - int'(32'd1 << bits);
  end
  return int'(raw);
endfunction

// unsigned data field that feeds a lane
function automatic int data_field(data_t d, int unsigned bits, int unsigned lane);
  int unsigned raw;
  raw = d;
  return int'((raw >> (bits * lane)) & ((32'd1 << bits) - 1));
endfunction

function automatic product_t expect_lane(prec_mode_t m, data_t d, weight_t w,
                                         int unsigned lane);
  int unsigned bits;
  int unsigned live;
  case (m)
    MODE_P8:
    begin
      bits = 8;
      live = 1;
    end
    MODE_P4:
    begin
      bits = 4;
      live = 2;
    end
    // reserved 00 runs as P2
    default:
    begin
      bits = 2;
      live = 4;
    end
  endcase
  // lanes the mode leaves idle read zero
  if (lane >= live)
  begin
    return '0;
  end
  return product_t'(data_field(d, bits, lane) * weight_field(w, bits));
endfunction

`endif

// ==== tb_multi_precision_mul.sv ====
`default_nettype none

module tb_multi_precision_mul;
  timeunit 1ns;
  timeprecision 100ps;

  import mul_operand_pkg::*;
  import prec_mode_pkg::*;

  `include "tb_mul_model.svh"

  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned N_P8       = 200;
  localparam int unsigned N_P4       = 200;
  localparam int unsigned N_P2       = 200;
  localparam int unsigned N_MIX      = 400;
  // drain and idle tail plus slack
  localparam int unsigned TIMEOUT_CYCLES =
    RST_CYCLES + N_P8 + N_P4 + N_P2 + N_MIX + 4 + 50;

  // expected products of one accepted set and the cycle they are due
  typedef struct packed {
    logic [31:0]              due;
    product_t [NUM_LANES-1:0] mul;
  } exp_set_t;

  logic          clk;
  logic          rst_n;
  logic          in_valid;
  prec_mode_t    in_mode;
  data_t         in_data;
  weight_t       in_w [NUM_LANES];
  wire           out_valid;
  wire product_t out_mul1;
  wire product_t out_mul2;
  wire product_t out_mul3;
  wire product_t out_mul4;

  exp_set_t    exp_q [$];
  int unsigned cycle_cnt  = 0;
  int unsigned n_checked  = 0;
  int unsigned value_errs = 0;
  int unsigned valid_errs = 0;

  multi_precision_mul i_multi_precision_mul (
    .clk     (clk),
    .i_rst_n (rst_n),
    .i_valid (in_valid),
    .i_mode  (in_mode),
    .i_data  (in_data),
    .i_w1    (in_w[0]),
    .i_w2    (in_w[1]),
    .i_w3    (in_w[2]),
    .i_w4    (in_w[3]),
    .o_valid (out_valid),
    .o_mul1  (out_mul1),
    .o_mul2  (out_mul2),
    .o_mul3  (out_mul3),
    .o_mul4  (out_mul4)
  );

  always #5 clk = ~clk;

  // rising edges seen so far
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_product(string name, product_t got, product_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp)
    begin
      valid_errs++;
      if (exp)
      begin
        $display("missing o_valid at %0d ns, a result was due and none came", $time);
      end
      else
      begin
        $display("unexpected o_valid at %0d ns, no result was due", $time);
      end
    end
  endtask

  // idle cycles expect low valid and zero products
  task automatic check_outputs();
    exp_set_t e;
    logic     due_now;
    due_now = (exp_q.size() != 0) && (exp_q[0].due == cycle_cnt);
    e = '0;
    if (due_now)
    begin
      e = exp_q.pop_front();
      n_checked++;
    end
    check_valid(out_valid, due_now);
    check_product("o_mul1", out_mul1, e.mul[0]);
    check_product("o_mul2", out_mul2, e.mul[1]);
    check_product("o_mul3", out_mul3, e.mul[2]);
    check_product("o_mul4", out_mul4, e.mul[3]);
  endtask

  // corner weights show up often
  function automatic weight_t random_weight();
    case ($urandom_range(5, 0))
      0: return weight_t'(-128);
      1: return '0;
      2: return weight_t'(127);
      default: return weight_t'($urandom);
    endcase
  endfunction

  function automatic prec_mode_t random_mode();
    case ($urandom_range(2, 0))
      0: return MODE_P2;
      1: return MODE_P4;
      default: return MODE_P8;
    endcase
  endfunction

  // sets driven now are sampled at the next rising edge
  task automatic drive_set(logic v, prec_mode_t m);
    exp_set_t e;
    in_valid = v;
    in_mode  = m;
    in_data  = data_t'($urandom);
    for (int k = 0; k < NUM_LANES; k++)
    begin
      in_w[k] = random_weight();
    end
    if (v && rst_n)
    begin
      e.due = cycle_cnt + 2;
      for (int k = 0; k < NUM_LANES; k++)
      begin
        e.mul[k] = expect_lane(m, in_data, in_w[k], k);
      end
      exp_q.push_back(e);
    end
  endtask

  // one cycle of checking and driving at the falling edge
  task automatic step(logic v, prec_mode_t m);
    @(negedge clk);
    check_outputs();
    if (cycle_cnt >= RST_CYCLES)
    begin
      rst_n = 1'b1;
    end
    drive_set(v, m);
  endtask

  initial
  begin
    void'($urandom(36));
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_mode  = MODE_P8;
    in_data  = '0;
    in_w     = '{default: '0};
    // live traffic during reset must not reach the outputs
    while (!rst_n)
    begin
      step($urandom_range(1, 0) == 1, random_mode());
    end
    repeat (N_P8) step(1'b1, MODE_P8);
    repeat (N_P4) step(1'b1, MODE_P4);
    repeat (N_P2) step(1'b1, MODE_P2);
    // random gaps in valid and a new mode every cycle
    repeat (N_MIX) step($urandom_range(9, 0) < 7, random_mode());
    while (exp_q.size() != 0)
    begin
      step(1'b0, MODE_P8);
    end
    // nothing extra after the last result
    repeat (2) step(1'b0, MODE_P8);
    $display("summary: %0d results checked, %0d value mismatches, %0d valid errors",
             n_checked, value_errs, valid_errs);
    if ((value_errs + valid_errs) == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  initial
  begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
